//--- src/key_sched_cfg.svh
`ifndef KEY_SCHED_CFG_SVH
`define KEY_SCHED_CFG_SVH

// AES-256 key schedule dimensions

// Key length in 32-bit words
`define KS_NK 8

// Rounds of the cipher
`define KS_NR 14

// One round key per round plus the initial one
`define KS_ROUND_KEYS 15

// Expanded schedule, w0 to w59
`define KS_TOTAL_WORDS 60

`define KS_WORD_W 32

// Serial S-box, one byte per cycle
`define KS_SUB_CYCLES 4

`endif

//--- src/aes_types_pkg.sv
`include "key_sched_cfg.svh"

package aes_types_pkg;

    typedef logic [7:0] aes_byte_t;

    typedef logic [`KS_WORD_W-1:0] aes_word_t;

    // Same 32 bits, seen as a word for XOR or as bytes for the S-box
    typedef union packed {
        aes_word_t w;
        aes_byte_t [3:0] b; // b[3] is the leftmost byte
    } aes_word_u;

    // w[4r] sits in the top word
    typedef logic [4*`KS_WORD_W-1:0] aes_round_key_t;

    // w0 sits in the top word
    typedef logic [`KS_NK*`KS_WORD_W-1:0] aes_cipher_key_t;

endpackage

//--- src/key_sched_pkg.sv
`include "key_sched_cfg.svh"

package key_sched_pkg;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,   // Copy key words w0..w7
        PLAIN,  // w[i-1] ^ w[i-8]
        SUBST,  // Serial SubWord, with RotWord and Rcon when i mod 8 is 0
        FINISH
    } ks_state_e;

    typedef logic [$clog2(`KS_TOTAL_WORDS)-1:0] ks_word_idx_t;

    typedef logic [$clog2(`KS_ROUND_KEYS)-1:0] ks_round_idx_t;

endpackage

//--- src/aes_sbox.sv
module aes_sbox (
    input  aes_types_pkg::aes_byte_t in_byte,
    output aes_types_pkg::aes_byte_t out_byte
);

    logic [127:0] row; // 16 entries for the high nibble

    always_comb begin
        case (in_byte[7:4])
            4'h0: row = 128'h637c777b_f26b6fc5_3001672b_fed7ab76;
            4'h1: row = 128'hca82c97d_fa5947f0_add4a2af_9ca472c0;
            4'h2: row = 128'hb7fd9326_363ff7cc_34a5e5f1_71d83115;
            4'h3: row = 128'h04c723c3_1896059a_071280e2_eb27b275;
            4'h4: row = 128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84;
            4'h5: row = 128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf;
            4'h6: row = 128'hd0efaafb_434d3385_45f9027f_503c9fa8;
            4'h7: row = 128'h51a3408f_929d38f5_bcb6da21_10fff3d2;
            4'h8: row = 128'hcd0c13ec_5f974417_c4a77e3d_645d1973;
            4'h9: row = 128'h60814fdc_222a9088_46eeb814_de5e0bdb;
            4'ha: row = 128'he0323a0a_4906245c_c2d3ac62_9195e479;
            4'hb: row = 128'he7c8376d_8dd54ea9_6c56f4ea_657aae08;
            4'hc: row = 128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a;
            4'hd: row = 128'h703eb566_4803f60e_613557b9_86c11d9e;
            4'he: row = 128'he1f89811_69d98e94_9b1e87e9_ce5528df;
            default: row = 128'h8ca1890d_bfe64268_41992d0f_b054bb16;
        endcase
    end

    // Column 0 is the leftmost byte of the row
    assign out_byte = row[{~in_byte[3:0], 3'b000} +: 8];

endmodule

//--- src/key_word_gen.sv
`include "key_sched_cfg.svh"

module key_word_gen (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start,
    input  aes_types_pkg::aes_cipher_key_t key,
    input  aes_types_pkg::aes_word_t       store_words [0:`KS_TOTAL_WORDS-1],
    output logic                           word_wr,
    output key_sched_pkg::ks_word_idx_t    word_idx,
    output aes_types_pkg::aes_word_t       word_data,
    output logic                           gen_busy,
    output logic                           gen_done
);

    key_sched_pkg::ks_state_e state;
    key_sched_pkg::ks_state_e after_wr;
    key_sched_pkg::ks_word_idx_t prev_idx, back_idx, next_idx;
    aes_types_pkg::aes_cipher_key_t key_reg;
    aes_types_pkg::aes_word_t prev_word, back_word, rcon_word, load_word;
    aes_types_pkg::aes_word_u src_u, sub_q, sub_d;
    aes_types_pkg::aes_byte_t rcon, sbox_out;
    logic [$clog2(`KS_SUB_CYCLES)-1:0] byte_cnt;
    logic rot_word, last_byte;

    assign gen_busy = (state == key_sched_pkg::LOAD) || (state == key_sched_pkg::PLAIN) ||
                      (state == key_sched_pkg::SUBST);
    assign gen_done = (state == key_sched_pkg::FINISH);

    assign prev_idx = word_idx - 1'b1;
    assign back_idx = key_sched_pkg::ks_word_idx_t'(word_idx - `KS_NK);
    assign next_idx = word_idx + 1'b1;

    assign prev_word = store_words[prev_idx];
    assign back_word = store_words[back_idx];
    assign load_word = key_reg[(`KS_NK - 1 - word_idx[2:0]) * `KS_WORD_W +: `KS_WORD_W];

    assign rot_word  = (word_idx[2:0] == 3'd0); // i mod 8 == 0
    assign last_byte = (byte_cnt == `KS_SUB_CYCLES - 1);
    assign rcon_word = rot_word ? {rcon, 24'h0} : '0;

    aes_sbox u_sbox (
        .in_byte  (src_u.b[byte_cnt]),
        .out_byte (sbox_out)
    );

    always_comb begin
        src_u.w = rot_word ? {prev_word[23:0], prev_word[31:24]} : prev_word;
        sub_d = sub_q;
        sub_d.b[byte_cnt] = sbox_out; // Fill in this cycle's byte
    end

    always_comb begin
        word_wr = 1'b0;
        word_data = '0;
        case (state)
            key_sched_pkg::LOAD: begin
                word_wr = 1'b1;
                word_data = load_word;
            end
            key_sched_pkg::PLAIN: begin
                word_wr = 1'b1;
                word_data = prev_word ^ back_word;
            end
            key_sched_pkg::SUBST: begin
                word_wr = last_byte;
                word_data = sub_d.w ^ back_word ^ rcon_word;
            end
            default: ;
        endcase
    end

    // Where the FSM goes once the current word is written
    always_comb begin
        if (word_idx == `KS_TOTAL_WORDS - 1)
            after_wr = key_sched_pkg::FINISH;
        else if (next_idx[1:0] == 2'd0)
            after_wr = key_sched_pkg::SUBST;
        else
            after_wr = key_sched_pkg::PLAIN;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= key_sched_pkg::IDLE;
            word_idx <= '0;
            byte_cnt <= '0;
            rcon <= 8'h01;
        end else begin
            case (state)
                key_sched_pkg::IDLE, key_sched_pkg::FINISH: begin
                    state <= start ? key_sched_pkg::LOAD : key_sched_pkg::IDLE;
                    word_idx <= '0;
                    byte_cnt <= '0;
                    rcon <= 8'h01;
                end
                key_sched_pkg::LOAD: begin
                    word_idx <= next_idx;
                    if (word_idx == `KS_NK - 1)
                        state <= after_wr;
                end
                key_sched_pkg::PLAIN: begin
                    word_idx <= next_idx;
                    state <= after_wr;
                end
                key_sched_pkg::SUBST: begin
                    byte_cnt <= byte_cnt + 1'b1; // Wraps to 0 after the last byte
                    if (last_byte) begin
                        word_idx <= next_idx;
                        state <= after_wr;
                        if (rot_word)
                            rcon <= {rcon[6:0], 1'b0} ^ (rcon[7] ? 8'h1b : 8'h00);
                    end
                end
                default: state <= key_sched_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && !gen_busy)
            key_reg <= key;
        if (state == key_sched_pkg::SUBST)
            sub_q <= sub_d;
    end

endmodule

//--- src/round_key_store.sv
`include "key_sched_cfg.svh"

module round_key_store (
    input  logic                          clk,
    input  logic                          word_wr,
    input  key_sched_pkg::ks_word_idx_t   word_idx,
    input  aes_types_pkg::aes_word_t      word_data,
    input  key_sched_pkg::ks_round_idx_t  rd_round,
    output aes_types_pkg::aes_word_t      store_words [0:`KS_TOTAL_WORDS-1],
    output aes_types_pkg::aes_round_key_t rd_key
);

    key_sched_pkg::ks_word_idx_t base_idx;

    // Round r starts at w[4r]
    assign base_idx = {rd_round, 2'b00};

    always_ff @(posedge clk) begin
        if (word_wr)
            store_words[word_idx] <= word_data;
    end

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            // w[4r] lands in the top word
            rd_key[(3 - k) * `KS_WORD_W +: `KS_WORD_W] =
                store_words[key_sched_pkg::ks_word_idx_t'(base_idx + k)];
        end
    end

endmodule

//--- src/round_key_reader.sv
`include "key_sched_cfg.svh"

module round_key_reader (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          gen_busy,
    input  logic                          gen_done,
    input  logic                          rk_req,
    input  key_sched_pkg::ks_round_idx_t  rk_index,
    input  aes_types_pkg::aes_round_key_t rd_key,
    output key_sched_pkg::ks_round_idx_t  rd_round,
    output logic                          rk_valid,
    output logic                          rk_error,
    output aes_types_pkg::aes_round_key_t round_key
);

    logic ready;  // A full schedule sits in the store
    logic idx_ok;

    assign rd_round = rk_index;
    assign idx_ok = ready && (rk_index <= `KS_NR);

    always_ff @(posedge clk) begin
        if (rst) begin
            ready <= 1'b0;
            rk_valid <= 1'b0;
            rk_error <= 1'b0;
        end else begin
            if (gen_busy)
                ready <= 1'b0; // Store is being rewritten
            else if (gen_done)
                ready <= 1'b1;
            rk_valid <= rk_req && idx_ok;
            rk_error <= rk_req && !idx_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (rk_req && idx_ok)
            round_key <= rd_key;
    end

endmodule

//--- src/key_expansion_top.sv
`include "key_sched_cfg.svh"

module key_expansion_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  aes_types_pkg::aes_cipher_key_t key,
    input  logic                          rk_req,
    input  key_sched_pkg::ks_round_idx_t  rk_index,
    output logic                          busy,
    output logic                          done,
    output logic                          rk_valid,
    output logic                          rk_error,
    output aes_types_pkg::aes_round_key_t round_key
);

    logic word_wr;
    key_sched_pkg::ks_word_idx_t word_idx;
    aes_types_pkg::aes_word_t word_data;
    aes_types_pkg::aes_word_t store_words [0:`KS_TOTAL_WORDS-1];
    key_sched_pkg::ks_round_idx_t rd_round;
    aes_types_pkg::aes_round_key_t rd_key;

    key_word_gen u_gen (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .key         (key),
        .store_words (store_words),
        .word_wr     (word_wr),
        .word_idx    (word_idx),
        .word_data   (word_data),
        .gen_busy    (busy),
        .gen_done    (done)
    );

    round_key_store u_store (
        .clk         (clk),
        .word_wr     (word_wr),
        .word_idx    (word_idx),
        .word_data   (word_data),
        .rd_round    (rd_round),
        .store_words (store_words),
        .rd_key      (rd_key)
    );

    round_key_reader u_reader (
        .clk       (clk),
        .rst       (rst),
        .gen_busy  (busy),
        .gen_done  (done),
        .rk_req    (rk_req),
        .rk_index  (rk_index),
        .rd_key    (rd_key),
        .rd_round  (rd_round),
        .rk_valid  (rk_valid),
        .rk_error  (rk_error),
        .round_key (round_key)
    );

endmodule

//--- test/tb_vectors.svh
// Columns: cipher key, round index, expect rk_error, expected round key
// Round keys are FIPS-197 A.3 values and the known all-zero key schedule

typedef struct packed {
    aes_types_pkg::aes_cipher_key_t key;
    key_sched_pkg::ks_round_idx_t   index;
    logic                           expect_error;
    aes_types_pkg::aes_round_key_t  round_key;
} vector_t;

localparam aes_types_pkg::aes_cipher_key_t KEY_FIPS_A3 =
    256'h603deb10_15ca71be_2b73aef0_857d7781_1f352c07_3b6108d7_2d9810a3_0914dff4;
localparam aes_types_pkg::aes_cipher_key_t KEY_ZERO = '0;

localparam int NUM_VECTORS = 11;
localparam int TABLE_KEYS = 2; // Key changes going down the table

localparam vector_t VECTORS [NUM_VECTORS] = '{
    '{KEY_FIPS_A3, 4'd0,  1'b0, 128'h603deb10_15ca71be_2b73aef0_857d7781},
    '{KEY_FIPS_A3, 4'd1,  1'b0, 128'h1f352c07_3b6108d7_2d9810a3_0914dff4},
    '{KEY_FIPS_A3, 4'd2,  1'b0, 128'h9ba35411_8e6925af_a51a8b5f_2067fcde},
    '{KEY_FIPS_A3, 4'd3,  1'b0, 128'ha8b09c1a_93d194cd_be49846e_b75d5b9a},
    '{KEY_FIPS_A3, 4'd14, 1'b0, 128'hfe4890d1_e6188d0b_046df344_706c631e},
    '{KEY_FIPS_A3, 4'd15, 1'b1, 128'h0},  // Past the last round key
    '{KEY_ZERO,    4'd0,  1'b0, 128'h0},
    '{KEY_ZERO,    4'd1,  1'b0, 128'h0},
    '{KEY_ZERO,    4'd2,  1'b0, 128'h62636363_62636363_62636363_62636363},
    '{KEY_ZERO,    4'd3,  1'b0, 128'haafbfbfb_aafbfbfb_aafbfbfb_aafbfbfb},
    '{KEY_ZERO,    4'd15, 1'b1, 128'h0}
};

//--- test/tb_key_expansion.sv
`include "key_sched_cfg.svh"

module tb_key_expansion;

    timeunit 1ns;
    timeprecision 1ps;

    `include "tb_vectors.svh"

    localparam int NUM_RANDOM = 4;
    localparam int NUM_KEYS = TABLE_KEYS + NUM_RANDOM + 2; // Two more for the restart case
    localparam int TIMEOUT_CYCLES = NUM_KEYS * 120 + 200;

    logic clk = 1'b0;
    logic rst;
    logic start;
    logic rk_req;
    aes_types_pkg::aes_cipher_key_t key;
    key_sched_pkg::ks_round_idx_t rk_index;
    logic busy;
    logic done;
    logic rk_valid;
    logic rk_error;
    aes_types_pkg::aes_round_key_t round_key;

    aes_types_pkg::aes_word_t model_w [0:`KS_TOTAL_WORDS-1];
    integer seed;
    int check_count = 0;
    int mismatch_count = 0;
    int cycle_count = 0;

    key_expansion_top dut (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .key       (key),
        .rk_req    (rk_req),
        .rk_index  (rk_index),
        .busy      (busy),
        .done      (done),
        .rk_valid  (rk_valid),
        .rk_error  (rk_error),
        .round_key (round_key)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic aes_types_pkg::aes_byte_t gf_mul(input aes_types_pkg::aes_byte_t a,
                                                        input aes_types_pkg::aes_byte_t b);
        aes_types_pkg::aes_byte_t p;
        aes_types_pkg::aes_byte_t m;
        p = '0;
        m = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i])
                p = p ^ m;
            m = {m[6:0], 1'b0} ^ (m[7] ? 8'h1b : 8'h00); // Reduce by x^8+x^4+x^3+x+1
        end
        return p;
    endfunction

    // Multiplicative inverse, then the affine map
    function automatic aes_types_pkg::aes_byte_t sbox_model(input aes_types_pkg::aes_byte_t x);
        aes_types_pkg::aes_byte_t inv;
        inv = 8'h01;
        for (int i = 0; i < 254; i++)
            inv = gf_mul(inv, x); // x^254 maps zero to zero
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]} ^
               {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

    function automatic aes_types_pkg::aes_word_t sub_word(input aes_types_pkg::aes_word_t w);
        return {sbox_model(w[31:24]), sbox_model(w[23:16]), sbox_model(w[15:8]),
                sbox_model(w[7:0])};
    endfunction

    function automatic void model_expand(input aes_types_pkg::aes_cipher_key_t k);
        aes_types_pkg::aes_word_t t;
        aes_types_pkg::aes_byte_t rc;
        rc = 8'h01;
        for (int i = 0; i < `KS_TOTAL_WORDS; i++) begin
            if (i < `KS_NK) begin
                model_w[i] = k[(`KS_NK - 1 - i) * `KS_WORD_W +: `KS_WORD_W];
            end else begin
                t = model_w[i-1];
                if (i % `KS_NK == 0) begin
                    t = sub_word({t[23:0], t[31:24]}) ^ {rc, 24'h0};
                    rc = gf_mul(rc, 8'h02);
                end else if (i % `KS_NK == 4) begin
                    t = sub_word(t);
                end
                model_w[i] = model_w[i-`KS_NK] ^ t;
            end
        end
    endfunction

    function automatic aes_types_pkg::aes_round_key_t model_round(input int r);
        return {model_w[4*r], model_w[4*r+1], model_w[4*r+2], model_w[4*r+3]};
    endfunction

    // Key capture cycle, eight load cycles, then the main phase
    function automatic int expected_run_cycles();
        int n;
        n = 1 + `KS_NK;
        for (int i = `KS_NK; i < `KS_TOTAL_WORDS; i++)
            n += (i % 8 == 0 || i % 8 == 4) ? `KS_SUB_CYCLES : 1;
        return n;
    endfunction

    function automatic aes_types_pkg::aes_cipher_key_t random_key();
        aes_types_pkg::aes_cipher_key_t k;
        k = '0;
        for (int j = 0; j < `KS_NK; j++)
            k = {k[223:0], 32'($random(seed))};
        return k;
    endfunction

    task automatic check_round_key(input aes_types_pkg::aes_round_key_t got,
                                   input aes_types_pkg::aes_round_key_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t ns: %s round key %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flags(input logic valid, input logic error, input logic exp_valid,
                               input logic exp_error, input string what);
        check_count++;
        if (valid !== exp_valid || error !== exp_error) begin
            mismatch_count++;
            $display("Mismatch at %0t ns: %s rk_valid %b rk_error %b, expected %b %b",
                     $time, what, valid, error, exp_valid, exp_error);
        end
    endtask

    task automatic check_status(input logic got_busy, input logic got_done,
                                input logic exp_busy, input logic exp_done, input string what);
        check_count++;
        if (got_busy !== exp_busy || got_done !== exp_done) begin
            mismatch_count++;
            $display("Mismatch at %0t ns: %s busy %b done %b, expected %b %b",
                     $time, what, got_busy, got_done, exp_busy, exp_done);
        end
    endtask

    task automatic check_cycles(input int got, input int exp, input string what);
        check_count++;
        if (got != exp) begin
            mismatch_count++;
            $display("Mismatch at %0t ns: %s took %0d cycles, expected %0d",
                     $time, what, got, exp);
        end
    endtask

    // Results come back one cycle after the request
    task automatic request_round(input key_sched_pkg::ks_round_idx_t idx, output logic valid,
                                 output logic error, output aes_types_pkg::aes_round_key_t rk);
        rk_req = 1'b1;
        rk_index = idx;
        @(posedge clk);
        #1;
        rk_req = 1'b0;
        valid = rk_valid;
        error = rk_error;
        rk = round_key;
    endtask

    task automatic expand_key(input aes_types_pkg::aes_cipher_key_t k, input logic restart,
                              input aes_types_pkg::aes_cipher_key_t other);
        int cycles;
        cycles = 0;
        key = k;
        start = 1'b1;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            start = 1'b0;
            rk_req = 1'b0;
            if (cycles == 1)
                check_status(busy, done, 1'b1, 1'b0, "after start");
            if (cycles == 4) begin
                rk_req = 1'b1; // Store is mid-rewrite here
                rk_index = '0;
            end
            if (cycles == 5)
                check_flags(rk_valid, rk_error, 1'b0, 1'b1, "request while busy");
            if (cycles == 6 && restart) begin
                key = other;
                start = 1'b1;
            end
        end while (!done);
        check_status(busy, done, 1'b0, 1'b1, "at done");
        check_cycles(cycles, expected_run_cycles(), "start to done");
        @(posedge clk); // ready follows done by one cycle
        #1;
        check_status(busy, done, 1'b0, 1'b0, "after done");
    endtask

    task automatic check_all_rounds(input aes_types_pkg::aes_cipher_key_t k);
        logic valid;
        logic error;
        aes_types_pkg::aes_round_key_t rk;
        model_expand(k);
        for (int r = 0; r < `KS_ROUND_KEYS; r++) begin
            request_round(key_sched_pkg::ks_round_idx_t'(r), valid, error, rk);
            check_flags(valid, error, 1'b1, 1'b0, $sformatf("round %0d", r));
            check_round_key(rk, model_round(r), $sformatf("round %0d", r));
            if (r == 0)
                check_round_key(rk, k[255:128], "round 0 against key high half");
            if (r == 1)
                check_round_key(rk, k[127:0], "round 1 against key low half");
        end
    endtask

    initial begin
        logic valid;
        logic error;
        logic have_key;
        aes_types_pkg::aes_round_key_t rk;
        aes_types_pkg::aes_cipher_key_t loaded_key;
        aes_types_pkg::aes_cipher_key_t key_a;
        aes_types_pkg::aes_cipher_key_t key_b;
        seed = 7740;
        rst = 1'b1;
        start = 1'b0;
        key = '0;
        rk_req = 1'b0;
        rk_index = '0;
        have_key = 1'b0;
        loaded_key = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // Nothing expanded yet
        request_round(4'd0, valid, error, rk);
        check_flags(valid, error, 1'b0, 1'b1, "request after reset");
        request_round(4'd14, valid, error, rk);
        check_flags(valid, error, 1'b0, 1'b1, "request after reset");

        for (int n = 0; n < NUM_VECTORS; n++) begin
            if (!have_key || VECTORS[n].key != loaded_key) begin
                expand_key(VECTORS[n].key, 1'b0, '0);
                check_all_rounds(VECTORS[n].key);
                loaded_key = VECTORS[n].key;
                have_key = 1'b1;
            end
            request_round(VECTORS[n].index, valid, error, rk);
            check_flags(valid, error, !VECTORS[n].expect_error, VECTORS[n].expect_error,
                        $sformatf("vector %0d", n));
            if (!VECTORS[n].expect_error)
                check_round_key(rk, VECTORS[n].round_key, $sformatf("vector %0d", n));
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            key_a = random_key();
            expand_key(key_a, 1'b0, '0);
            check_all_rounds(key_a);
        end

        // Second start while busy must not disturb the first key
        key_a = random_key();
        key_b = random_key();
        expand_key(key_a, 1'b1, key_b);
        check_all_rounds(key_a);
        expand_key(key_b, 1'b0, '0);
        check_all_rounds(key_b);

        $display("Checks: %0d, mismatches: %0d", check_count, mismatch_count);
        if (mismatch_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- project.f
+incdir+src
+incdir+test
src/aes_types_pkg.sv
src/key_sched_pkg.sv
src/aes_sbox.sv
src/key_word_gen.sv
src/round_key_store.sv
src/round_key_reader.sv
src/key_expansion_top.sv
test/tb_key_expansion.sv

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_key_expansion --Mdir obj_dir -o tb_sim -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
    exit 0
fi

echo "Pass message not found in $LOG"
exit 1
